//--- flist.f
+incdir+rtl
rtl/usb_track_pkg.sv
rtl/usb_pullup_detect.sv
rtl/usb_drive_track.sv
rtl/usb_line_report.sv
rtl/usb_bus_track.sv
testbench/usb_bus_track_asserts.sv
testbench/usb_bus_track_checker.sv
testbench/tb_usb_bus_track.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the USB bus tracker testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_usb_bus_track \
  -o sim_tb >sim.log 2>&1 && ./obj_dir/sim_tb >>sim.log 2>&1
grep -q "Everything OK" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

//--- testbench/tb_usb_bus_track.sv
/* Testbench for the USB bus direction tracker
   Plays a per-cycle stimulus table into the DUT and reports the checker verdict */

`timescale 1ns/100ps

module tb_usb_bus_track;

  import usb_track_pkg::*;

  localparam int MAX_ROWS = 256;

  logic        clk_i;
  logic        rst_ni;
  logic        enable;
  logic        sense;
  logic        host_dp_en;
  logic        host_dn_en;
  logic        usb_p;
  logic        usb_n;
  logic        pullup_dp;
  logic        pullup_dn;
  logic        dev_dp_en;
  logic        dev_dn_en;
  line_state_e line_state;
  pkt_cnt_t    pkt_cnt;
  int          err_cnt;
  int          chk_cnt;

  // Row columns from bit 6 down are reset, enable, sense, host D+, host D-, D+ and D-
  logic [6:0]   row_bits [MAX_ROWS];
  logic [127:0] row_name [MAX_ROWS];
  logic [127:0] cur_name;
  int           n_rows;
  int           cycle_cnt;
  logic         table_ready;
  logic [31:0]  lfsr_q;

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  usb_bus_track u_usb_bus_track (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (enable),
    .sense_i      (sense),
    .host_dp_en_i (host_dp_en),
    .host_dn_en_i (host_dn_en),
    .usb_p_i      (usb_p),
    .usb_n_i      (usb_n),
    .pullup_dp_o  (pullup_dp),
    .pullup_dn_o  (pullup_dn),
    .dev_dp_en_o  (dev_dp_en),
    .dev_dn_en_o  (dev_dn_en),
    .line_state_o (line_state),
    .pkt_cnt_o    (pkt_cnt)
  );

  usb_bus_track_checker u_checker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .test_name_i  (cur_name),
    .enable_i     (enable),
    .sense_i      (sense),
    .host_dp_en_i (host_dp_en),
    .host_dn_en_i (host_dn_en),
    .usb_p_i      (usb_p),
    .usb_n_i      (usb_n),
    .pullup_dp_i  (pullup_dp),
    .pullup_dn_i  (pullup_dn),
    .dev_dp_en_i  (dev_dp_en),
    .dev_dn_en_i  (dev_dn_en),
    .line_state_i (line_state),
    .pkt_cnt_i    (pkt_cnt),
    .err_cnt_o    (err_cnt),
    .chk_cnt_o    (chk_cnt)
  );

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  task automatic take_rand_bit(output logic bit_o);
    bit_o  = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  task automatic add_rows(input logic [127:0] name, input int count, input logic [6:0] bits);
    repeat (count) begin
      row_bits[n_rows] = bits;
      row_name[n_rows] = name;
      n_rows++;
    end
  endtask

  // Bus activity with tracking on where differential rows keep D- the inverse of D+
  task automatic add_random_rows(input logic [127:0] name, input int count,
                                 input logic host_dp, input logic diff);
    logic p;
    logic n;
    repeat (count) begin
      take_rand_bit(p);
      if (diff) begin
        n = ~p;
      end else begin
        take_rand_bit(n);
      end
      add_rows(name, 1, {3'b011, host_dp, 1'b0, p, n});
    end
  endtask

  task automatic apply_row(input int idx);
    rst_ni     = ~row_bits[idx][6];
    enable     = row_bits[idx][5];
    sense      = row_bits[idx][4];
    host_dp_en = row_bits[idx][3];
    host_dn_en = row_bits[idx][2];
    usb_p      = row_bits[idx][1];
    usb_n      = row_bits[idx][0];
    cur_name   = row_name[idx];
  endtask

  task automatic build_table();
    // Without sense or without enable a high D+ must not latch
    add_rows("gate_attach", 2, 7'b0_10_00_10);
    add_rows("gate_attach", 2, 7'b0_01_00_10);
    add_rows("attach_dp", 2, 7'b0_11_00_00);
    add_rows("attach_dp", 3, 7'b0_11_00_10);
    // A host resume K after the attach puts D- high and leaves the D- flag low
    add_rows("attach_dp", 2, 7'b0_11_11_01);
    add_rows("attach_dp", 2, 7'b0_11_00_10);
    // A K from the device claims the bus at once
    add_rows("dev_packet", 1, 7'b0_11_00_01);
    add_random_rows("dev_packet", 6, 1'b0, 1'b1);
    add_rows("short_se0", 3, 7'b0_11_00_00);
    add_rows("short_se0", 1, 7'b0_11_00_10);
    add_random_rows("short_se0", 3, 1'b0, 1'b1);
    add_rows("eop", 8, 7'b0_11_00_00);
    add_rows("eop", 3, 7'b0_11_00_10);
    add_random_rows("host_override", 8, 1'b1, 1'b0);
    add_rows("host_override", 8, 7'b0_11_00_00);
    add_rows("host_override", 2, 7'b0_11_00_10);
    // Tracking gated off by enable and then by sense
    add_rows("gating", 3, 7'b0_01_00_01);
    add_rows("gating", 3, 7'b0_10_00_01);
    add_rows("gating", 2, 7'b0_11_00_10);
    // An owned line survives a long SE0 while enable is low
    add_rows("gating", 1, 7'b0_11_00_01);
    add_rows("gating", 10, 7'b0_01_00_00);
    add_rows("gating", 8, 7'b0_11_00_00);
    add_rows("gating", 2, 7'b0_11_00_10);
    // A fresh reset and then a pin-flipped device pulling D- high
    add_rows("attach_flip", 4, 7'b1_00_00_00);
    add_rows("attach_flip", 2, 7'b0_11_00_00);
    add_rows("attach_flip", 3, 7'b0_11_00_01);
    add_rows("attach_flip", 1, 7'b0_11_00_10);
    add_random_rows("attach_flip", 4, 1'b0, 1'b1);
    add_rows("attach_flip", 8, 7'b0_11_00_00);
    add_rows("attach_flip", 3, 7'b0_11_00_01);
    add_random_rows("random", 20, 1'b0, 1'b0);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    rst_ni      = 1'b0;
    enable      = 1'b0;
    sense       = 1'b0;
    host_dp_en  = 1'b0;
    host_dn_en  = 1'b0;
    usb_p       = 1'b0;
    usb_n       = 1'b0;
    cur_name    = "reset";
    n_rows      = 0;
    table_ready = 1'b0;
    lfsr_q      = 32'h54fb;
    build_table();
    table_ready = 1'b1;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(negedge clk_i);
      apply_row(i);
    end
    // Let the checker see the last row
    repeat (2) @(negedge clk_i);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", chk_cnt, err_cnt,
             u_usb_bus_track.u_asserts.fail_cnt);
    if (err_cnt == 0 && u_usb_bus_track.u_asserts.fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // The whole run fits in the table length plus reset and drain cycles
  initial begin
    cycle_cnt = 0;
    wait (table_ready);
    while (cycle_cnt <= n_rows + 20) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the stimulus table did not finish within %0d cycles", n_rows + 20);
    $display("Something failed");
    $finish;
  end

endmodule

//--- testbench/usb_bus_track_checker.sv
/* Reference model and output checker for the USB bus direction tracker
   Samples the DUT at each rising edge and compares every output */

`timescale 1ns/100ps

`include "usb_track_params.svh"

module usb_bus_track_checker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [127:0]               test_name_i,
  input  logic                       enable_i,
  input  logic                       sense_i,
  input  logic                       host_dp_en_i,
  input  logic                       host_dn_en_i,
  input  logic                       usb_p_i,
  input  logic                       usb_n_i,
  input  logic                       pullup_dp_i,
  input  logic                       pullup_dn_i,
  input  logic                       dev_dp_en_i,
  input  logic                       dev_dn_en_i,
  input  usb_track_pkg::line_state_e line_state_i,
  input  usb_track_pkg::pkt_cnt_t    pkt_cnt_i,
  output int                         err_cnt_o,
  output int                         chk_cnt_o
);

  import usb_track_pkg::*;

  // Model state, all of it as seen just before the current edge
  logic        m_pu_dp;
  logic        m_pu_dn;
  logic        m_own_dp;
  logic        m_own_dn;
  se0_cnt_t    m_se0;
  line_state_e m_ls;
  pkt_cnt_t    m_pkt;
  // Per-sample values
  logic        track;
  logic        exp_dp_en;
  logic        exp_dn_en;
  logic        eop;
  logic        rel_dp;
  logic        rel_dn;
  logic        j_lvl;
  logic        k_lvl;
  int          err_cnt;
  int          chk_cnt;

  assign err_cnt_o = err_cnt;
  assign chk_cnt_o = chk_cnt;

  initial begin
    err_cnt = 0;
    chk_cnt = 0;
  end

  task automatic compare_value(input string sig, input int exp_val, input int act_val);
    chk_cnt++;
    if (exp_val != act_val) begin
      err_cnt++;
      $display("[ERROR] %0s: %0s expected %0h actual %0h", test_name_i, sig, exp_val, act_val);
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      m_pu_dp  = 1'b0;
      m_pu_dn  = 1'b0;
      m_own_dp = 1'b0;
      m_own_dn = 1'b0;
      m_se0    = '0;
      m_ls     = LS_SE0;
      m_pkt    = '0;
    end else begin
      ////////////////////
      // Expected outputs
      ////////////////////
      // A line is claimed when it leaves Idle, and Idle is the pull-up level
      track     = enable_i && sense_i && (m_pu_dp || m_pu_dn);
      exp_dp_en = !host_dp_en_i && (m_own_dp || (track && (usb_p_i != m_pu_dp)));
      exp_dn_en = !host_dn_en_i && (m_own_dn || (track && (usb_n_i != m_pu_dn)));
      compare_value("pullup_dp_o", int'(m_pu_dp), int'(pullup_dp_i));
      compare_value("pullup_dn_o", int'(m_pu_dn), int'(pullup_dn_i));
      compare_value("dev_dp_en_o", int'(exp_dp_en), int'(dev_dp_en_i));
      compare_value("dev_dn_en_o", int'(exp_dn_en), int'(dev_dn_en_i));
      compare_value("line_state_o", int'(m_ls), int'(line_state_i));
      compare_value("pkt_cnt_o", int'(m_pkt), int'(pkt_cnt_i));
      ////////////////////
      // Model update
      ////////////////////
      // The 8th SE0 sample in a row gives owned lines back
      eop    = track && (m_se0 == se0_cnt_t'(`USB_SE0_END_CNT));
      rel_dp = eop && m_own_dp && !host_dp_en_i;
      rel_dn = eop && m_own_dn && !host_dn_en_i;
      if (track) begin
        m_own_dp = exp_dp_en && !rel_dp;
        m_own_dn = exp_dn_en && !rel_dn;
      end
      if (enable_i && !usb_p_i && !usb_n_i) begin
        m_se0 = m_se0 + se0_cnt_t'(1);
      end else begin
        m_se0 = '0;
      end
      if (rel_dp || rel_dn) begin
        m_pkt = m_pkt + pkt_cnt_t'(1);
      end
      // Flipped devices carry J on the D- wire
      j_lvl = m_pu_dn ? usb_n_i : usb_p_i;
      k_lvl = m_pu_dn ? usb_p_i : usb_n_i;
      if (j_lvl && !k_lvl) begin
        m_ls = LS_J;
      end else if (k_lvl && !j_lvl) begin
        m_ls = LS_K;
      end else if (j_lvl) begin
        m_ls = LS_SE1;
      end else begin
        m_ls = LS_SE0;
      end
      if (enable_i && sense_i && !m_pu_dp && !m_pu_dn) begin
        m_pu_dp = usb_p_i;
        m_pu_dn = usb_n_i;
      end
    end
  end

endmodule

//--- testbench/usb_bus_track_asserts.sv
/* Bound assertions for the USB bus direction tracker
   Sticky pull-up flags, host versus device exclusion, single-cycle releases */

`timescale 1ns/100ps

module usb_bus_track_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic host_dp_en_i,
  input logic host_dn_en_i,
  input logic pullup_dp_i,
  input logic pullup_dn_i,
  input logic dev_dp_en_i,
  input logic dev_dn_en_i,
  input logic dev_release_i
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  ////////////////////
  // Pull-up flags
  ////////////////////

  // Once the attach is seen the flags hold until the next reset
  pullup_dp_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pullup_dp_i |=> pullup_dp_i)
    else begin
      fail_cnt++;
      $error("D+ pull-up flag fell without a reset");
    end

  pullup_dn_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pullup_dn_i |=> pullup_dn_i)
    else begin
      fail_cnt++;
      $error("D- pull-up flag fell without a reset");
    end

  ////////////////////
  // Bus ownership
  ////////////////////

  // The host and the device never both drive the same line
  dp_owner_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dev_dp_en_i && host_dp_en_i))
    else begin
      fail_cnt++;
      $error("device and host both drive D+");
    end

  dn_owner_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dev_dn_en_i && host_dn_en_i))
    else begin
      fail_cnt++;
      $error("device and host both drive D-");
    end

  // A release lasts one cycle because the SE0 counter cannot end two runs in a row
  release_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dev_release_i |=> !dev_release_i)
    else begin
      fail_cnt++;
      $error("device release held high for two cycles");
    end

endmodule

bind usb_bus_track usb_bus_track_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .host_dp_en_i  (host_dp_en_i),
  .host_dn_en_i  (host_dn_en_i),
  .pullup_dp_i   (pullup_dp),
  .pullup_dn_i   (pullup_dn),
  .dev_dp_en_i   (dev_dp_en_o),
  .dev_dn_en_i   (dev_dn_en_o),
  .dev_release_i (dev_release)
);

//--- rtl/usb_bus_track.sv
/* Full-speed USB bus direction tracker
   Pull-up detection, device drive tracking and line state report */

`timescale 1ns/100ps

module usb_bus_track (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       sense_i,
  input  logic                       host_dp_en_i,
  input  logic                       host_dn_en_i,
  input  logic                       usb_p_i,
  input  logic                       usb_n_i,
  output logic                       pullup_dp_o,
  output logic                       pullup_dn_o,
  output logic                       dev_dp_en_o,
  output logic                       dev_dn_en_o,
  output usb_track_pkg::line_state_e line_state_o,
  output usb_track_pkg::pkt_cnt_t    pkt_cnt_o
);

  // Pull-up flags fan out to both downstream blocks
  logic pullup_dp;
  logic pullup_dn;
  // End of a device packet, one cycle wide
  logic dev_release;

  ////////////////////
  // Input side
  ////////////////////

  usb_pullup_detect u_pullup_detect (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .enable_i    (enable_i),
    .sense_i     (sense_i),
    .usb_p_i     (usb_p_i),
    .usb_n_i     (usb_n_i),
    .pullup_dp_o (pullup_dp),
    .pullup_dn_o (pullup_dn)
  );

  ////////////////////
  // Drive tracking
  ////////////////////

  usb_drive_track u_drive_track (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .enable_i      (enable_i),
    .sense_i       (sense_i),
    .pullup_dp_i   (pullup_dp),
    .pullup_dn_i   (pullup_dn),
    .host_dp_en_i  (host_dp_en_i),
    .host_dn_en_i  (host_dn_en_i),
    .usb_p_i       (usb_p_i),
    .usb_n_i       (usb_n_i),
    .dev_dp_en_o   (dev_dp_en_o),
    .dev_dn_en_o   (dev_dn_en_o),
    .dev_release_o (dev_release)
  );

  ////////////////////
  // Output side
  ////////////////////

  // Only the D- flag is needed here since it alone selects the flip
  usb_line_report u_line_report (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pullup_dn_i   (pullup_dn),
    .dev_release_i (dev_release),
    .usb_p_i       (usb_p_i),
    .usb_n_i       (usb_n_i),
    .line_state_o  (line_state_o),
    .pkt_cnt_o     (pkt_cnt_o)
  );

  assign pullup_dp_o = pullup_dp;
  assign pullup_dn_o = pullup_dn;

endmodule

//--- rtl/usb_line_report.sv
/* Line state report
   Registers the pin-flip corrected bus state and counts device packets */

`timescale 1ns/100ps

module usb_line_report (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     pullup_dn_i,
  input  logic                     dev_release_i,
  input  logic                     usb_p_i,
  input  logic                     usb_n_i,
  output usb_track_pkg::line_state_e line_state_o,
  output usb_track_pkg::pkt_cnt_t    pkt_cnt_o
);

  import usb_track_pkg::*;

  logic        j_line;
  logic        k_line;
  line_state_e line_state_d;
  line_state_e line_state_q;
  pkt_cnt_t    pkt_cnt_q;

  ////////////////////
  // Flip correction
  ////////////////////

  // A flipped device carries its true D+ on usb_n, so the roles swap
  // Before any pull-up is latched usb_p is taken as the J line
  assign j_line = pullup_dn_i ? usb_n_i : usb_p_i;
  assign k_line = pullup_dn_i ? usb_p_i : usb_n_i;

  always_comb begin
    unique case ({k_line, j_line})
      2'b00:   line_state_d = LS_SE0;
      2'b01:   line_state_d = LS_J;
      2'b10:   line_state_d = LS_K;
      default: line_state_d = LS_SE1;
    endcase
  end

  // One cycle from sample to report
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_state_q <= LS_SE0;
    end else begin
      line_state_q <= line_state_d;
    end
  end

  ////////////////////
  // Packet counter
  ////////////////////

  // Each release pulse marks the end of one device packet
  // The count wraps silently at its width
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pkt_cnt_q <= '0;
    end else if (dev_release_i) begin
      pkt_cnt_q <= pkt_cnt_q + 1'b1;
    end
  end

  assign line_state_o = line_state_q;
  assign pkt_cnt_o    = pkt_cnt_q;

endmodule

//--- rtl/usb_drive_track.sv
/* Device drive tracking
   Rebuilds per-line device drive enables from departures out of bus Idle
   and hands the lines back after an SE0 run that marks end of packet */

`timescale 1ns/100ps

`include "usb_track_params.svh"

module usb_drive_track (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic sense_i,
  input  logic pullup_dp_i,
  input  logic pullup_dn_i,
  input  logic host_dp_en_i,
  input  logic host_dn_en_i,
  input  logic usb_p_i,
  input  logic usb_n_i,
  output logic dev_dp_en_o,
  output logic dev_dn_en_o,
  output logic dev_release_o
);

  import usb_track_pkg::*;

  // Bit 0 is the usb_p wire and bit 1 the usb_n wire throughout this block
  logic [1:0] line;
  logic [1:0] idle;
  logic [1:0] host_en;
  logic [1:0] claim;
  logic [1:0] dev_en;
  logic [1:0] dev_en_q;
  logic [1:0] release_vec;
  logic       track_en;
  logic       se0;
  logic       se0_end;
  se0_cnt_t   se0_cnt_q;

  assign line    = {usb_n_i, usb_p_i};
  assign host_en = {host_dn_en_i, host_dp_en_i};

  // The wire carrying the true D+ rests high, so Idle is just the pull-up flag
  assign idle = {pullup_dn_i, pullup_dp_i};

  // Tracking only makes sense with VSENSE applied and a device attached
  assign track_en = enable_i & sense_i & (pullup_dp_i | pullup_dn_i);

  ////////////////////
  // SE0 run counter
  ////////////////////

  assign se0 = ~usb_p_i & ~usb_n_i;

  // This is only an approximation of EOP and it also runs during bus reset
  // Any non-SE0 sample, or tracking switched off, restarts the run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      se0_cnt_q <= '0;
    end else if (enable_i && se0) begin
      se0_cnt_q <= se0_cnt_q + 1'b1;
    end else begin
      se0_cnt_q <= '0;
    end
  end

  // True while the 8th SE0 sample in a row is on the bus
  assign se0_end = (se0_cnt_q == se0_cnt_t'(`USB_SE0_END_CNT));

  ////////////////////
  // Drive enables
  ////////////////////

  // A line that leaves its Idle level is being driven by the device
  assign claim = track_en ? (line ^ idle) : 2'b00;

  // The host enables win, otherwise ownership is held or newly claimed
  // Claiming is combinational so the enable rises in the departing cycle
  assign dev_en = ~host_en & (dev_en_q | claim);

  // An owned line goes back once the SE0 run reaches its end count
  assign release_vec = {2{track_en & se0_end}} & dev_en_q & ~host_en;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dev_en_q <= 2'b00;
    end else if (track_en) begin
      // Host driving also clears ownership, since dev_en is low then
      dev_en_q <= dev_en & ~release_vec;
    end
  end

  assign dev_dp_en_o = dev_en[0];
  assign dev_dn_en_o = dev_en[1];

  // One pulse per finished packet even when both lines were owned
  assign dev_release_o = |release_vec;

endmodule

//--- rtl/usb_pullup_detect.sv
/* Pull-up detection
   Latches the first line the device pulls high once VSENSE is applied */

`timescale 1ns/100ps

module usb_pullup_detect (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic sense_i,
  input  logic usb_p_i,
  input  logic usb_n_i,
  output logic pullup_dp_o,
  output logic pullup_dn_o
);

  ////////////////////
  // Detection window
  ////////////////////

  logic pullup_dp_q;
  logic pullup_dn_q;
  logic pullup_seen;
  logic detect_en;

  // Once either flag is set the device is attached and later line activity
  // is ordinary traffic, so the window closes for good
  assign pullup_seen = pullup_dp_q | pullup_dn_q;

  // Only look while the host is tracking and VSENSE is present
  assign detect_en = enable_i & sense_i & ~pullup_seen;

  ////////////////////
  // Sticky flags
  ////////////////////

  // Both flags may set on the same edge if both lines read high together
  // A set D- flag means the device is pin-flipped, its true D+ sits on usb_n
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pullup_dp_q <= 1'b0;
      pullup_dn_q <= 1'b0;
    end else if (detect_en) begin
      if (usb_p_i) begin
        pullup_dp_q <= 1'b1;
      end
      if (usb_n_i) begin
        pullup_dn_q <= 1'b1;
      end
    end
  end

  // The flags also give the Idle level of each line to the rest of the tracker
  assign pullup_dp_o = pullup_dp_q;
  assign pullup_dn_o = pullup_dn_q;

endmodule

//--- rtl/usb_track_pkg.sv
/* Types shared by the USB bus tracker and its testbench
   Counter vectors and the flip-corrected line state */

package usb_track_pkg;

  `include "usb_track_params.svh"

  ////////////////////
  // Counter types
  ////////////////////

  // Length of the current run of SE0 samples
  typedef logic [`USB_SE0_CNT_W-1:0] se0_cnt_t;

  // Number of device packets seen so far, wraps on overflow
  typedef logic [`USB_PKT_CNT_W-1:0] pkt_cnt_t;

  ////////////////////
  // Bus line state
  ////////////////////

  // State of the pair after the pin-flip correction has been applied
  // J and K are named from the true D+ and D- roles, not the wires
  typedef enum logic [1:0] {
    LS_SE0 = 2'b00,
    LS_J   = 2'b01,
    LS_K   = 2'b10,
    LS_SE1 = 2'b11
  } line_state_e;

endpackage

//--- rtl/usb_track_params.svh
/* USB bus tracker constants
   End-of-packet SE0 run length and the widths of the tracker counters */

`ifndef USB_TRACK_PARAMS_SVH
`define USB_TRACK_PARAMS_SVH

////////////////////
// SE0 run detection
////////////////////

// Counter value at which a device-owned line is handed back
// Eight SE0 samples in a row are two full-speed bit times at four samples per bit
`define USB_SE0_END_CNT 7

// Wide enough to hold the end count, the counter wraps past it
`define USB_SE0_CNT_W 3

////////////////////
// Packet counting
////////////////////

// Finished device packets are counted modulo 2**width
`define USB_PKT_CNT_W 8

`endif
